//--- source/board_timing_pkg.sv
`default_nettype none

package board_timing_pkg;

  // sample clock count, correction offset and trigger time
  typedef logic [63:0] clkcnt_t;

  // one coefficient word
  typedef logic [31:0] coef_t;

  // coefficient index, row * COEF_COLS + column
  typedef logic [5:0] coef_addr_t;

  // coefficient bank dimensions, 64 entries in all
  localparam int COEF_ROWS = 8;
  localparam int COEF_COLS = 8;

  // sysref edge counter width and the number of rises needed to arm
  localparam int SYSREF_EDGE_CNT_W = 3;
  localparam int SYSREF_ARM_EDGES = 4;

  // arming sequence
  typedef enum logic [1:0] {
    IDLE,
    WAIT_SYSREF,
    RUNNING
  } arm_state_e;

endpackage

`default_nettype wire

//--- source/sysref_arm_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module sysref_arm_fsm (
  input  logic dspclk,
  input  logic reset,
  input  logic arm_en,
  input  logic sysref,
  input  logic soft_reset_stb,
  output logic count_en,
  output logic dsp_reset
);

  // edge count value at which the next counted rise arms
  localparam logic [board_timing_pkg::SYSREF_EDGE_CNT_W-1:0] last_edge =
    board_timing_pkg::SYSREF_EDGE_CNT_W'(board_timing_pkg::SYSREF_ARM_EDGES - 1);

  // sysref sampling pair, q1 is the newer sample
  logic sysref_q1;
  logic sysref_q2;
  logic sysref_rise;

  logic count_rise;
  logic [board_timing_pkg::SYSREF_EDGE_CNT_W-1:0] edge_cnt;

  board_timing_pkg::arm_state_e arm_state;
  board_timing_pkg::arm_state_e arm_state_nxt;

  // sysref is asynchronous to dspclk
  always_ff @(posedge dspclk) begin
    sysref_q1 <= sysref;
    sysref_q2 <= sysref_q1;
  end

  assign sysref_rise = sysref_q1 & ~sysref_q2;

  // only count while the host enables arming and we are waiting
  assign count_rise = sysref_rise & arm_en &
                      (arm_state == board_timing_pkg::WAIT_SYSREF);

  always_ff @(posedge dspclk) begin
    if (reset) begin
      edge_cnt <= '0;
    end else if (count_rise) begin
      edge_cnt <= edge_cnt + 1'b1;
    end
  end

  // next state
  always_comb begin
    arm_state_nxt = arm_state;
    case (arm_state)
      board_timing_pkg::IDLE: begin
        if (arm_en) begin
          arm_state_nxt = board_timing_pkg::WAIT_SYSREF;
        end
      end
      board_timing_pkg::WAIT_SYSREF: begin
        // fourth counted rise
        if (count_rise && edge_cnt == last_edge) begin
          arm_state_nxt = board_timing_pkg::RUNNING;
        end
      end
      board_timing_pkg::RUNNING: begin
        // stays armed until reset
        arm_state_nxt = board_timing_pkg::RUNNING;
      end
      default: begin
        arm_state_nxt = board_timing_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge dspclk) begin
    if (reset) begin
      arm_state <= board_timing_pkg::IDLE;
    end else begin
      arm_state <= arm_state_nxt;
    end
  end

  // armed one edge after the state reaches RUNNING
  always_ff @(posedge dspclk) begin
    if (reset) begin
      count_en <= 1'b0;
    end else begin
      count_en <= (arm_state == board_timing_pkg::RUNNING);
    end
  end

  // board reset or host soft reset, one cycle late
  always_ff @(posedge dspclk) begin
    dsp_reset <= reset | soft_reset_stb;
  end

endmodule

`default_nettype wire

//--- source/sample_clock_counter.sv
`timescale 1ns/1ns
`default_nettype none

module sample_clock_counter (
  input  logic                      dspclk,
  input  logic                      reset,
  input  logic                      count_en,
  input  logic                      corr_sel,
  input  board_timing_pkg::clkcnt_t corr,
  input  board_timing_pkg::clkcnt_t trig_time,
  output board_timing_pkg::clkcnt_t clkcnt,
  output logic                      trig_level
);

  // free-running count since arming
  board_timing_pkg::clkcnt_t raw_count;

  // raw count plus host correction, one cycle behind raw_count
  board_timing_pkg::clkcnt_t corr_count;

  always_ff @(posedge dspclk) begin
    if (reset) begin
      raw_count <= '0;
    end else if (count_en) begin
      raw_count <= raw_count + 64'd1;
    end
  end

  always_ff @(posedge dspclk) begin
    if (reset) begin
      corr_count <= '0;
    end else begin
      corr_count <= raw_count + corr;
    end
  end

  // host picks the corrected or the raw count
  assign clkcnt = corr_sel ? corr_count : raw_count;

  // trigger stays high once the count has reached trig_time
  always_ff @(posedge dspclk) begin
    if (reset) begin
      trig_level <= 1'b0;
    end else begin
      trig_level <= (clkcnt >= trig_time);
    end
  end

endmodule

`default_nettype wire

//--- source/coef_bank.sv
`timescale 1ns/1ns
`default_nettype none

module coef_bank (
  input  logic                         dspclk,
  input  logic                         reset,
  input  logic                         coef_wstb,
  input  board_timing_pkg::coef_addr_t coef_waddr,
  input  board_timing_pkg::coef_t      coef_wdata,
  input  logic                         coef_rstb,
  input  board_timing_pkg::coef_addr_t coef_raddr,
  input  board_timing_pkg::coef_addr_t dsp_coef_addr,
  output board_timing_pkg::coef_t      coef_rdata,
  output board_timing_pkg::coef_t      dsp_coef
);

  // row by column, address is row * COEF_COLS + column
  board_timing_pkg::coef_t coef_mem [board_timing_pkg::COEF_ROWS][board_timing_pkg::COEF_COLS];

  // host write
  always_ff @(posedge dspclk) begin
    if (coef_wstb) begin
      coef_mem[coef_waddr / board_timing_pkg::COEF_COLS]
              [coef_waddr % board_timing_pkg::COEF_COLS] <= coef_wdata;
    end
  end

  // host readback, holds between strobes
  always_ff @(posedge dspclk) begin
    if (reset) begin
      coef_rdata <= '0;
    end else if (coef_rstb) begin
      coef_rdata <= coef_mem[coef_raddr / board_timing_pkg::COEF_COLS]
                            [coef_raddr % board_timing_pkg::COEF_COLS];
    end
  end

  // DSP side read, every cycle
  // a same-cycle write is seen on the following read
  always_ff @(posedge dspclk) begin
    dsp_coef <= coef_mem[dsp_coef_addr / board_timing_pkg::COEF_COLS]
                        [dsp_coef_addr % board_timing_pkg::COEF_COLS];
  end

endmodule

`default_nettype wire

//--- source/board_timing.sv
`timescale 1ns/1ns
`default_nettype none

module board_timing (
  input  logic                         dspclk,
  input  logic                         reset,

  // arming
  input  logic                         arm_en,
  input  logic                         sysref,

  // clock counter and trigger
  input  board_timing_pkg::clkcnt_t    corr,
  input  logic                         corr_sel,
  input  board_timing_pkg::clkcnt_t    trig_time,
  input  logic                         soft_reset_stb,

  // coefficient host access and DSP read
  input  logic                         coef_wstb,
  input  board_timing_pkg::coef_addr_t coef_waddr,
  input  board_timing_pkg::coef_t      coef_wdata,
  input  logic                         coef_rstb,
  input  board_timing_pkg::coef_addr_t coef_raddr,
  input  board_timing_pkg::coef_addr_t dsp_coef_addr,

  output logic                         armed,
  output board_timing_pkg::clkcnt_t    clkcnt,
  output logic                         trig_level,
  output logic                         dsp_reset,
  output board_timing_pkg::coef_t      coef_rdata,
  output board_timing_pkg::coef_t      dsp_coef
);

  // counter runs once the arming sequence is done
  logic count_en;

  assign armed = count_en;

  sysref_arm_fsm sysref_arm_fsm_i (
    .dspclk         (dspclk),
    .reset          (reset),
    .arm_en         (arm_en),
    .sysref         (sysref),
    .soft_reset_stb (soft_reset_stb),
    .count_en       (count_en),
    .dsp_reset      (dsp_reset)
  );

  sample_clock_counter sample_clock_counter_i (
    .dspclk     (dspclk),
    .reset      (reset),
    .count_en   (count_en),
    .corr_sel   (corr_sel),
    .corr       (corr),
    .trig_time  (trig_time),
    .clkcnt     (clkcnt),
    .trig_level (trig_level)
  );

  coef_bank coef_bank_i (
    .dspclk        (dspclk),
    .reset         (reset),
    .coef_wstb     (coef_wstb),
    .coef_waddr    (coef_waddr),
    .coef_wdata    (coef_wdata),
    .coef_rstb     (coef_rstb),
    .coef_raddr    (coef_raddr),
    .dsp_coef_addr (dsp_coef_addr),
    .coef_rdata    (coef_rdata),
    .dsp_coef      (dsp_coef)
  );

endmodule

`default_nettype wire

//--- verif/board_timing_sva.sv
`timescale 1ns/1ns
`default_nettype none

module board_timing_sva (
  input logic dspclk,
  input logic reset,
  input logic soft_reset_stb,
  input logic count_en,
  input logic dsp_reset
);

  // assertion failure count
  int error_count = 0;

  // once armed, only a board reset can drop the count enable
  count_en_hold: assert property (@(posedge dspclk) $fell(count_en) |-> $past(reset))
    else begin
      error_count++;
      $error("count_en fell while reset was low");
    end

  // soft reset strobe shows up on dsp_reset one cycle later
  dsp_reset_on_strobe: assert property (@(posedge dspclk) soft_reset_stb |=> dsp_reset)
    else begin
      error_count++;
      $error("dsp_reset did not follow soft_reset_stb");
    end

  dsp_reset_release: assert property (
    @(posedge dspclk) !(reset || soft_reset_stb) |=> !dsp_reset)
    else begin
      error_count++;
      $error("dsp_reset high without reset or soft reset");
    end

endmodule

bind sysref_arm_fsm board_timing_sva board_timing_sva_i (
  .dspclk         (dspclk),
  .reset          (reset),
  .soft_reset_stb (soft_reset_stb),
  .count_en       (count_en),
  .dsp_reset      (dsp_reset)
);

`default_nettype wire

//--- verif/board_timing_tb.sv
`timescale 1ns/1ns
`default_nettype none

module board_timing_tb;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 16;
  localparam int RESET_TEST_CYCLES = 4;
  localparam int NOARM_CYCLES = 40;
  localparam int ARM_MAX_CYCLES = 60;
  localparam int ARM_WAIT_CYCLES = 8;
  localparam int COUNT_CYCLES = 50;
  localparam int CORR_CYCLES = 48;
  localparam int TRIG_CYCLES = 80;
  localparam int COEF_RANDOM_CYCLES = 200;
  localparam int COEF_CYCLES = 64 + COEF_RANDOM_CYCLES + 4;
  localparam int TOTAL_CYCLES = RESET_CYCLES + RESET_TEST_CYCLES + NOARM_CYCLES + 3 +
                                ARM_MAX_CYCLES + COUNT_CYCLES + CORR_CYCLES +
                                TRIG_CYCLES + COEF_CYCLES;
  localparam int WATCHDOG_NS = (TOTAL_CYCLES + 200) * CLK_PERIOD;

  logic dspclk;
  logic reset;
  logic arm_en;
  logic sysref;
  logic corr_sel;
  logic soft_reset_stb;
  logic coef_wstb;
  logic coef_rstb;
  logic armed;
  logic trig_level;
  logic dsp_reset;
  board_timing_pkg::clkcnt_t corr;
  board_timing_pkg::clkcnt_t trig_time;
  board_timing_pkg::clkcnt_t clkcnt;
  board_timing_pkg::coef_addr_t coef_waddr;
  board_timing_pkg::coef_addr_t coef_raddr;
  board_timing_pkg::coef_addr_t dsp_coef_addr;
  board_timing_pkg::coef_t coef_wdata;
  board_timing_pkg::coef_t coef_rdata;
  board_timing_pkg::coef_t dsp_coef;

  // reference model state
  board_timing_pkg::clkcnt_t m_raw;
  board_timing_pkg::clkcnt_t m_corr;
  logic m_armed;
  logic m_trig;
  logic m_dsp_reset;
  board_timing_pkg::coef_t m_coef [64];
  logic m_known [64];
  board_timing_pkg::coef_t m_rdata;
  logic m_rdata_known;
  board_timing_pkg::coef_t m_dsp;
  logic m_dsp_known;

  logic [31:0] rng_state;
  string test_name;
  int test_errors;
  int total_errors;
  int tests_run;
  int tests_failed;
  int check_count;
  int sva_errors;

  board_timing board_timing_i (
    .dspclk         (dspclk),
    .reset          (reset),
    .arm_en         (arm_en),
    .sysref         (sysref),
    .corr           (corr),
    .corr_sel       (corr_sel),
    .trig_time      (trig_time),
    .soft_reset_stb (soft_reset_stb),
    .coef_wstb      (coef_wstb),
    .coef_waddr     (coef_waddr),
    .coef_wdata     (coef_wdata),
    .coef_rstb      (coef_rstb),
    .coef_raddr     (coef_raddr),
    .dsp_coef_addr  (dsp_coef_addr),
    .armed          (armed),
    .clkcnt         (clkcnt),
    .trig_level     (trig_level),
    .dsp_reset      (dsp_reset),
    .coef_rdata     (coef_rdata),
    .dsp_coef       (dsp_coef)
  );

  initial begin
    dspclk = 1'b0;
    forever #(CLK_PERIOD / 2) dspclk = ~dspclk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

  // xorshift32
  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi, lo};
  endfunction

  // one clock edge with the model following the inputs held across it
  task automatic tick();
    board_timing_pkg::clkcnt_t pre_clk;
    pre_clk = corr_sel ? m_corr : m_raw;
    @(posedge dspclk);
    if (reset) begin
      m_raw = '0;
      m_corr = '0;
      m_trig = 1'b0;
      m_armed = 1'b0;
      m_rdata = '0;
      m_rdata_known = 1'b1;
    end else begin
      m_trig = (pre_clk >= trig_time);
      m_corr = m_raw + corr;
      if (m_armed) begin
        m_raw = m_raw + 64'd1;
      end
      // reads see the contents before this edge's write
      if (coef_rstb) begin
        m_rdata = m_coef[coef_raddr];
        m_rdata_known = m_known[coef_raddr];
      end
    end
    m_dsp = m_coef[dsp_coef_addr];
    m_dsp_known = m_known[dsp_coef_addr];
    m_dsp_reset = reset | soft_reset_stb;
    if (coef_wstb) begin
      m_coef[coef_waddr] = coef_wdata;
      m_known[coef_waddr] = 1'b1;
    end
    #1;
  endtask

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] got);
    check_count++;
    assert (got === exp) else begin
      $display("Mismatch in test %s, %s: expected %0h, actual %0h", test_name, what, exp, got);
      test_errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    check_count++;
    assert (cond) else begin
      $display("Error in test %s: %s", test_name, msg);
      test_errors++;
    end
  endtask

  task automatic compare_outputs();
    compare("clkcnt", corr_sel ? m_corr : m_raw, clkcnt);
    compare("trig_level", m_trig, trig_level);
    compare("dsp_reset", m_dsp_reset, dsp_reset);
    if (m_rdata_known) begin
      compare("coef_rdata", m_rdata, coef_rdata);
    end
    if (m_dsp_known) begin
      compare("dsp_coef", m_dsp, dsp_coef);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
  endtask

  task automatic idle_inputs();
    coef_wstb = 1'b0;
    coef_rstb = 1'b0;
    soft_reset_stb = 1'b0;
  endtask

  task automatic reset_values();
    int i;
    begin_test("reset_values");
    compare("armed", 0, armed);
    compare("dsp_reset during last reset cycle", 1, dsp_reset);
    compare_outputs();
    tick();
    compare("dsp_reset after reset", 0, dsp_reset);
    for (i = 0; i < RESET_TEST_CYCLES - 1; i++) begin
      compare("armed", 0, armed);
      compare_outputs();
      tick();
    end
    end_test();
  endtask

  task automatic arm_sequence();
    logic [31:0] r;
    int i;
    int n;
    int p;
    int wait_cycles;
    begin_test("arming");
    // sysref activity without arm_en must not arm
    arm_en = 1'b0;
    for (i = 0; i < NOARM_CYCLES; i++) begin
      r = rand32();
      sysref = r[0];
      tick();
      compare("armed with arm_en low", 0, armed);
      compare_outputs();
    end
    sysref = 1'b0;
    repeat (3) begin
      tick();
      compare_outputs();
    end
    arm_en = 1'b1;
    for (p = 1; p <= 4; p++) begin
      sysref = 1'b0;
      n = 2 + rand32() % 3;
      repeat (n) begin
        tick();
        compare("armed before fourth rise", 0, armed);
        compare_outputs();
      end
      sysref = 1'b1;
      if (p < 4) begin
        n = 2 + rand32() % 3;
        repeat (n) begin
          tick();
          compare("armed before fourth rise", 0, armed);
          compare_outputs();
        end
      end
    end
    wait_cycles = 0;
    while (armed !== 1'b1 && wait_cycles < ARM_WAIT_CYCLES) begin
      tick();
      compare_outputs();
      wait_cycles++;
    end
    expect_true(armed === 1'b1, "armed did not rise after the fourth sysref rise");
    m_armed = 1'b1;
    sysref = 1'b0;
    end_test();
  endtask

  task automatic count_steps();
    int i;
    begin_test("counting");
    corr_sel = 1'b0;
    for (i = 0; i < COUNT_CYCLES; i++) begin
      tick();
      compare("armed", 1, armed);
      compare_outputs();
    end
    end_test();
  endtask

  task automatic correction_offset();
    int i;
    begin_test("correction");
    corr_sel = 1'b1;
    for (i = 0; i < CORR_CYCLES; i++) begin
      if (i % 8 == 0) begin
        corr = rand64();
      end
      tick();
      compare("armed", 1, armed);
      compare_outputs();
    end
    end_test();
  endtask

  task automatic trigger_compare();
    logic [31:0] r;
    board_timing_pkg::clkcnt_t base;
    int i;
    begin_test("trigger");
    for (i = 0; i < TRIG_CYCLES; i++) begin
      // new trigger time a few counts around the current clkcnt
      if (i % 5 == 0) begin
        r = rand32();
        if (i % 20 == 0) begin
          corr_sel = r[31];
        end
        base = corr_sel ? m_corr : m_raw;
        trig_time = base + 64'(r % 32'd16) - 64'd6;
      end
      tick();
      compare_outputs();
    end
    end_test();
  endtask

  task automatic coef_access();
    logic [31:0] r;
    int a;
    int i;
    begin_test("coef_bank");
    for (a = 0; a < 64; a++) begin
      coef_wstb = 1'b1;
      coef_waddr = a[5:0];
      coef_wdata = rand32();
      dsp_coef_addr = a[5:0];
      tick();
      compare_outputs();
    end
    for (i = 0; i < COEF_RANDOM_CYCLES; i++) begin
      r = rand32();
      coef_wstb = r[0];
      coef_rstb = r[1];
      coef_waddr = r[13:8];
      // sometimes read the address being written
      coef_raddr = r[2] ? r[13:8] : r[21:16];
      dsp_coef_addr = r[3] ? r[13:8] : r[29:24];
      coef_wdata = rand32();
      tick();
      compare_outputs();
    end
    idle_inputs();
    tick();
    compare_outputs();
    soft_reset_stb = 1'b1;
    tick();
    compare("dsp_reset after soft reset", 1, dsp_reset);
    compare_outputs();
    soft_reset_stb = 1'b0;
    tick();
    compare("dsp_reset release", 0, dsp_reset);
    compare_outputs();
    tick();
    compare_outputs();
    end_test();
  endtask

  initial begin
    rng_state = 32'd28119;
    reset = 1'b1;
    arm_en = 1'b0;
    sysref = 1'b0;
    corr = '0;
    corr_sel = 1'b0;
    trig_time = '1;
    soft_reset_stb = 1'b0;
    coef_wstb = 1'b0;
    coef_waddr = '0;
    coef_wdata = '0;
    coef_rstb = 1'b0;
    coef_raddr = '0;
    dsp_coef_addr = '0;
    m_raw = '0;
    m_corr = '0;
    m_armed = 1'b0;
    m_trig = 1'b0;
    m_dsp_reset = 1'b1;
    m_rdata = '0;
    m_rdata_known = 1'b0;
    m_dsp = '0;
    m_dsp_known = 1'b0;
    for (int k = 0; k < 64; k++) begin
      m_known[k] = 1'b0;
    end
    tests_run = 0;
    tests_failed = 0;
    total_errors = 0;
    check_count = 0;

    repeat (RESET_CYCLES) tick();
    reset = 1'b0;

    reset_values();
    arm_sequence();
    count_steps();
    correction_offset();
    trigger_compare();
    coef_access();

    sva_errors = board_timing_i.sysref_arm_fsm_i.board_timing_sva_i.error_count;
    if (sva_errors != 0) begin
      $display("bound assertions failed %0d times", sva_errors);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, check_count, total_errors, sva_errors);
    if (tests_failed == 0 && sva_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
source/board_timing_pkg.sv
source/sysref_arm_fsm.sv
source/sample_clock_counter.sv
source/coef_bank.sv
source/board_timing.sv
verif/board_timing_sva.sv
verif/board_timing_tb.sv
